// File: common/phase_bus_pkg.sv
`default_nettype none

package phase_bus_pkg;

    // Backplane geometry
    localparam int NUM_BOARDS = 4;          // Plug-in boards on the bus
    localparam logic [3:0] BOARD_ALL = 4'd15; // Broadcast select, every board latches

    // Board port map, 3-bit port address
    localparam logic [2:0] PORT_MUX      = 3'd3; // Analog mux channel latch
    localparam logic [2:0] PORT_CONVERT  = 3'd4; // Write starts a conversion
    localparam logic [2:0] PORT_ADC_HIGH = 3'd5; // Result, upper byte
    localparam logic [2:0] PORT_ADC_LOW  = 3'd6; // Result, lower byte

    // Access timing in clock cycles
    localparam int SETTLE_CYCLES = 8; // Address and data hold before the strobe
    localparam int STROBE_CYCLES = 2; // Strobe low time
    localparam int TIMER_WIDTH   = 4; // Wide enough for both phases

    // Stream buffering
    localparam int CMD_DEPTH = 4;
    localparam int RSP_DEPTH = 4;

    // Largest response, ADC4 gives high and low per board
    localparam int MAX_RSP_BYTES = 8;

    // Command opcodes
    typedef enum logic [1:0] {
        WRITE4 = 2'd0, // One byte to the same port of every board
        READ4  = 2'd1, // Same port read back from every board
        ADC4   = 2'd2, // Mux, convert, read all boards
        ADC1   = 2'd3  // Mux, convert, read one board
    } opcode_t;

    // One command from the sender
    typedef struct packed {
        opcode_t                         opcode;
        logic [2:0]                      port;    // WRITE4 and READ4
        logic [1:0]                      board;   // ADC1 only
        logic [7:0]                      channel; // Mux channel for ADC4 and ADC1
        logic [NUM_BOARDS-1:0][7:0]      data;    // WRITE4, data[n] goes to board n
    } cmd_t;

    // One response per command
    typedef struct packed {
        opcode_t                         opcode;  // Echo of the command opcode
        logic [3:0]                      count;   // Valid bytes, 0, 2, 4 or 8
        logic [MAX_RSP_BYTES-1:0][7:0]   bytes;   // bytes[0] first, unused zero
    } rsp_t;

endpackage

`default_nettype wire

// File: phase_bus/phase_bus_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module phase_bus_sequencer (
    input  wire logic                 clock,
    input  wire logic                 reset,

    // Command stream, one command in flight
    input  wire logic                 cmd_valid,
    input  wire phase_bus_pkg::cmd_t  cmd,
    output logic                      cmd_credit, // Returned with the response

    // Response stream
    output logic                      rsp_valid,
    output phase_bus_pkg::rsp_t       rsp,
    input  wire logic                 rsp_credit,

    // Phase bus
    output logic [3:0]                board_sel,
    output logic [2:0]                addr_port,
    output logic                      rd_n,       // Read strobe, active low
    output logic                      wr_n,       // Write strobe, active low
    output logic [7:0]                data_out,
    output logic                      data_dir,   // 1 drives data_out onto the bus
    input  wire logic [7:0]           data_in
);

    // One FSM for all four commands
    typedef enum logic [2:0] {
        IDLE,    // Bus released, waiting for a command
        CREDIT,  // Command held, waiting for response space
        ADDR,    // Drive select, port and data
        SETTLE,  // Hold before the strobe
        STROBE,  // Strobe low
        RELEASE, // Strobe high again, address still held
        DONE     // Push response, return command credit
    } state_t;

    state_t state;

    phase_bus_pkg::cmd_t cmd_q;  // Latched command
    phase_bus_pkg::rsp_t rsp_q;  // Response under construction

    logic [3:0] step;       // Index into the access list
    logic [3:0] last_step;  // Final index for this opcode
    logic [3:0] rel_step;   // Step counted from the first ADC read
    logic [phase_bus_pkg::TIMER_WIDTH-1:0] timer; // Settle and strobe counter

    logic [$clog2(phase_bus_pkg::RSP_DEPTH+1)-1:0] rsp_cred; // Free response slots

    // Current access, decoded from opcode and step
    logic [3:0] acc_board;
    logic [2:0] acc_port;
    logic       acc_write;
    logic [7:0] acc_data;

    logic read_sample; // Last low cycle of a read

    assign rel_step = step - 4'd2; // ADC reads start after mux and convert writes

    // Access list decode
    always_comb begin
        acc_board = {2'b00, step[1:0]};
        acc_port  = cmd_q.port;
        acc_write = 1'b0;
        acc_data  = 8'h00;
        last_step = 4'(phase_bus_pkg::NUM_BOARDS - 1);
        case (cmd_q.opcode)
            phase_bus_pkg::WRITE4: begin
                acc_write = 1'b1;
                acc_data  = cmd_q.data[step[1:0]]; // Board n gets data[n]
            end
            phase_bus_pkg::READ4: begin
                acc_write = 1'b0; // Board order 0 to 3, same port
            end
            phase_bus_pkg::ADC4: begin
                last_step = 4'(2 * phase_bus_pkg::NUM_BOARDS + 1); // 2 writes, 8 reads
                if (step == 4'd0) begin
                    acc_board = phase_bus_pkg::BOARD_ALL; // Mux channel to all
                    acc_port  = phase_bus_pkg::PORT_MUX;
                    acc_write = 1'b1;
                    acc_data  = cmd_q.channel;
                end else if (step == 4'd1) begin
                    acc_board = phase_bus_pkg::BOARD_ALL; // Start every converter
                    acc_port  = phase_bus_pkg::PORT_CONVERT;
                    acc_write = 1'b1;
                end else begin
                    acc_board = {2'b00, rel_step[2:1]}; // Two reads per board
                    acc_port  = rel_step[0] ? phase_bus_pkg::PORT_ADC_LOW
                                            : phase_bus_pkg::PORT_ADC_HIGH;
                end
            end
            phase_bus_pkg::ADC1: begin
                last_step = 4'd3;
                acc_board = {2'b00, cmd_q.board}; // Chosen board only
                if (step == 4'd0) begin
                    acc_port  = phase_bus_pkg::PORT_MUX;
                    acc_write = 1'b1;
                    acc_data  = cmd_q.channel;
                end else if (step == 4'd1) begin
                    acc_port  = phase_bus_pkg::PORT_CONVERT;
                    acc_write = 1'b1;
                end else begin
                    acc_port  = rel_step[0] ? phase_bus_pkg::PORT_ADC_LOW
                                            : phase_bus_pkg::PORT_ADC_HIGH;
                end
            end
            default: begin
                acc_write = 1'b0;
            end
        endcase
    end

    assign read_sample = (state == STROBE) && (timer == '0) && !acc_write;

    // Response leaves in DONE, the command credit goes back with it
    assign rsp_valid  = (state == DONE);
    assign cmd_credit = rsp_valid;
    assign rsp        = rsp_q;

    // Control path
    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            step     <= 4'd0;
            timer    <= '0;
            rd_n     <= 1'b1; // Strobes idle high
            wr_n     <= 1'b1;
            data_dir <= 1'b0; // Bus released
            rsp_cred <= ($clog2(phase_bus_pkg::RSP_DEPTH+1))'(phase_bus_pkg::RSP_DEPTH);
        end else begin
            // Spent on push, refilled as the response FIFO drains
            rsp_cred <= rsp_cred
                        + ($clog2(phase_bus_pkg::RSP_DEPTH+1))'(rsp_credit)
                        - ($clog2(phase_bus_pkg::RSP_DEPTH+1))'(rsp_valid);

            case (state)
                IDLE: begin
                    step <= 4'd0;
                    if (cmd_valid) begin
                        state <= CREDIT;
                    end
                end

                CREDIT: begin
                    // Bus stays released while the response side is full
                    if (rsp_cred != '0) begin
                        state <= ADDR;
                    end
                end

                ADDR: begin
                    data_dir <= acc_write;  // Turn the bus around with the address
                    timer    <= phase_bus_pkg::TIMER_WIDTH'(phase_bus_pkg::SETTLE_CYCLES - 1);
                    state    <= SETTLE;
                end

                SETTLE: begin
                    if (timer == '0) begin
                        wr_n  <= !acc_write; // Only one strobe goes low
                        rd_n  <= acc_write;
                        timer <= phase_bus_pkg::TIMER_WIDTH'(phase_bus_pkg::STROBE_CYCLES - 1);
                        state <= STROBE;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                STROBE: begin
                    if (timer == '0) begin
                        rd_n  <= 1'b1; // Read data taken this cycle
                        wr_n  <= 1'b1; // Boards latch on this rising edge
                        state <= RELEASE;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                RELEASE: begin
                    if (step == last_step) begin
                        state <= DONE;
                    end else begin
                        step  <= step + 4'd1;
                        state <= ADDR;
                    end
                end

                DONE: begin
                    data_dir <= 1'b0; // Release before idling
                    state    <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Payload path, no reset
    always_ff @(posedge clock) begin
        if (state == IDLE && cmd_valid) begin
            cmd_q <= cmd;
            rsp_q <= '{opcode: cmd.opcode, count: 4'd0, bytes: '0}; // Unused bytes zero
        end
        if (state == ADDR) begin
            board_sel <= acc_board;
            addr_port <= acc_port;
            data_out  <= acc_data; // Zero on reads
        end
        if (read_sample) begin
            // Bytes fill in access order, board by board
            rsp_q.bytes[rsp_q.count[$clog2(phase_bus_pkg::MAX_RSP_BYTES)-1:0]] <= data_in;
            rsp_q.count <= rsp_q.count + 4'd1;
        end
    end

endmodule

`default_nettype wire

// File: project.f
common/phase_bus_pkg.sv
src/credit_fifo.sv
phase_bus/phase_bus_sequencer.sv
src/phase_bus_top.sv
tests/board_model.sv
tests/phase_bus_sva.sv
tests/phase_bus_tb.sv

// File: src/credit_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module credit_fifo #(
    parameter type T           = logic, // Payload type
    parameter int  DEPTH       = 4,     // Entries, at least 2
    parameter int  OUT_CREDITS = 1      // Credits granted by the consumer
) (
    input  wire logic clock,
    input  wire logic reset,

    // Producer side
    input  wire logic in_valid,
    input  wire T     in_data,
    output logic      in_credit,  // One pulse per entry that leaves

    // Consumer side
    output logic      out_valid,
    output T          out_data,
    input  wire logic out_credit  // Consumer hands a slot back
);

    T mem [DEPTH]; // Circular storage

    logic [$clog2(DEPTH)-1:0]       wr_ptr;
    logic [$clog2(DEPTH)-1:0]       rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]     count;   // Entries held
    logic [$clog2(OUT_CREDITS+1)-1:0] credits; // Slots free at the consumer
    logic                           pop;

    // Oldest entry is offered as soon as there is somewhere to send it
    assign out_valid = (count != '0) && (credits != '0);
    assign out_data  = mem[rd_ptr];
    assign pop       = out_valid; // Consumer never refuses, so valid means sent

    // Payload write, no reset needed
    always_ff @(posedge clock) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= ($clog2(OUT_CREDITS+1))'(OUT_CREDITS); // Full grant at start
            in_credit <= 1'b0;
        end else begin
            // Write side, sender guarantees space
            if (in_valid) begin
                if (int'(wr_ptr) == DEPTH - 1) begin
                    wr_ptr <= '0; // Wrap
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            // Read side
            if (pop) begin
                if (int'(rd_ptr) == DEPTH - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            // Occupancy, push and pop may coincide
            count <= count
                     + ($clog2(DEPTH+1))'(in_valid)
                     - ($clog2(DEPTH+1))'(pop);

            // Spend on send, refill on returned credit
            credits <= credits
                       + ($clog2(OUT_CREDITS+1))'(out_credit)
                       - ($clog2(OUT_CREDITS+1))'(pop);

            // Slot freed here goes back to the producer a cycle later
            in_credit <= pop;
        end
    end

endmodule

`default_nettype wire

// File: src/phase_bus_top.sv
`default_nettype none
`timescale 1ns/10ps

module phase_bus_top (
    input  wire logic                 clock,
    input  wire logic                 reset,

    // Command stream from the sender
    input  wire logic                 cmd_valid,
    input  wire phase_bus_pkg::cmd_t  cmd,
    output logic                      cmd_credit,

    // Response stream to the consumer
    output logic                      rsp_valid,
    output phase_bus_pkg::rsp_t       rsp,
    input  wire logic                 rsp_credit,

    // Backplane
    output logic [3:0]                board_sel,
    output logic [2:0]                addr_port,
    output logic                      rd_n,
    output logic                      wr_n,
    output logic [7:0]                data_out,
    output logic                      data_dir,
    input  wire logic [7:0]           data_in
);

    // Command FIFO to sequencer
    logic                seq_cmd_valid;
    phase_bus_pkg::cmd_t seq_cmd;
    logic                seq_cmd_credit;

    // Sequencer to response FIFO
    logic                seq_rsp_valid;
    phase_bus_pkg::rsp_t seq_rsp;
    logic                seq_rsp_credit;

    // Sequencer takes one command at a time
    credit_fifo #(
        .T           (phase_bus_pkg::cmd_t),
        .DEPTH       (phase_bus_pkg::CMD_DEPTH),
        .OUT_CREDITS (1)
    ) cmd_fifo (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (cmd_valid),
        .in_data    (cmd),
        .in_credit  (cmd_credit),
        .out_valid  (seq_cmd_valid),
        .out_data   (seq_cmd),
        .out_credit (seq_cmd_credit)
    );

    phase_bus_sequencer sequencer (
        .clock      (clock),
        .reset      (reset),
        .cmd_valid  (seq_cmd_valid),
        .cmd        (seq_cmd),
        .cmd_credit (seq_cmd_credit),
        .rsp_valid  (seq_rsp_valid),
        .rsp        (seq_rsp),
        .rsp_credit (seq_rsp_credit),
        .board_sel  (board_sel),
        .addr_port  (addr_port),
        .rd_n       (rd_n),
        .wr_n       (wr_n),
        .data_out   (data_out),
        .data_dir   (data_dir),
        .data_in    (data_in)
    );

    // External consumer grants RSP_DEPTH credits
    credit_fifo #(
        .T           (phase_bus_pkg::rsp_t),
        .DEPTH       (phase_bus_pkg::RSP_DEPTH),
        .OUT_CREDITS (phase_bus_pkg::RSP_DEPTH)
    ) rsp_fifo (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (seq_rsp_valid),
        .in_data    (seq_rsp),
        .in_credit  (seq_rsp_credit),
        .out_valid  (rsp_valid),
        .out_data   (rsp),
        .out_credit (rsp_credit)
    );

endmodule

`default_nettype wire

// File: tests/board_model.sv
`default_nettype none
`timescale 1ns/10ps

module board_model (
    input  wire logic [3:0] board_sel,
    input  wire logic [2:0] addr_port,
    input  wire logic       rd_n,
    input  wire logic       wr_n,
    input  wire logic [7:0] data_out,
    output logic [7:0]      data_in
);

    logic [7:0] port_mem    [phase_bus_pkg::NUM_BOARDS][8]; // Eight port bytes per board
    logic [7:0] result_high [phase_bus_pkg::NUM_BOARDS];    // ADC result register
    logic [7:0] result_low  [phase_bus_pkg::NUM_BOARDS];

    // Boards power up cleared
    initial begin
        for (int b = 0; b < phase_bus_pkg::NUM_BOARDS; b++) begin
            for (int p = 0; p < 8; p++) begin
                port_mem[b][p] = 8'h00;
            end
            result_high[b] = 8'h00;
            result_low[b]  = 8'h00;
        end
    end

    // Boards latch on the rising edge of the write strobe
    always @(posedge wr_n) begin
        for (int b = 0; b < phase_bus_pkg::NUM_BOARDS; b++) begin
            if (board_sel == phase_bus_pkg::BOARD_ALL || board_sel == 4'(b)) begin
                port_mem[b][addr_port] <= data_out;
                if (addr_port == phase_bus_pkg::PORT_CONVERT) begin
                    // Conversion uses the channel held in the mux latch
                    result_high[b] <= {4'(b), port_mem[b][phase_bus_pkg::PORT_MUX][3:0]};
                    result_low[b]  <= port_mem[b][phase_bus_pkg::PORT_MUX] ^ 8'hA5 ^ 8'(b);
                end
            end
        end
    end

    // Selected board answers only while rd_n is low
    assign data_in = rd_n ? 8'h00 :
                     (addr_port == phase_bus_pkg::PORT_ADC_HIGH) ? result_high[board_sel[1:0]] :
                     (addr_port == phase_bus_pkg::PORT_ADC_LOW)  ? result_low[board_sel[1:0]] :
                     port_mem[board_sel[1:0]][addr_port];

endmodule

`default_nettype wire

// File: tests/phase_bus_sva.sv
`default_nettype none
`timescale 1ns/10ps

module phase_bus_sva (
    input wire logic       clock,
    input wire logic       reset,
    input wire logic       rd_n,
    input wire logic       wr_n,
    input wire logic       data_dir,
    input wire logic [3:0] board_sel,
    input wire logic [2:0] addr_port,
    input wire logic       rsp_valid,
    input wire logic       rsp_credit
);

    int sva_errors = 0; // Failed assertion count
    int credits_left;   // Response credits held by the top level

    always_ff @(posedge clock) begin
        if (reset) begin
            credits_left <= phase_bus_pkg::RSP_DEPTH;
        end else begin
            credits_left <= credits_left + int'(rsp_credit) - int'(rsp_valid);
        end
    end

    strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(!rd_n && !wr_n))
        else begin sva_errors++; $error("rd_n and wr_n low together"); end

    addr_stable: assert property (@(posedge clock) disable iff (reset)
        (!rd_n || !wr_n) |=> ((rd_n && wr_n) || ($stable(board_sel) && $stable(addr_port))))
        else begin sva_errors++; $error("Address moved under a low strobe"); end

    dir_on_write: assert property (@(posedge clock) disable iff (reset) !wr_n |-> data_dir)
        else begin sva_errors++; $error("Write strobe without bus drive"); end

    dir_on_read: assert property (@(posedge clock) disable iff (reset) !rd_n |-> !data_dir)
        else begin sva_errors++; $error("Read strobe while driving the bus"); end

    wr_width: assert property (@(posedge clock) disable iff (reset)
        $fell(wr_n) |-> !wr_n [*phase_bus_pkg::STROBE_CYCLES] ##1 wr_n)
        else begin sva_errors++; $error("Write strobe width wrong"); end

    rd_width: assert property (@(posedge clock) disable iff (reset)
        $fell(rd_n) |-> !rd_n [*phase_bus_pkg::STROBE_CYCLES] ##1 rd_n)
        else begin sva_errors++; $error("Read strobe width wrong"); end

    // Checked during reset itself
    strobes_after_reset: assert property (@(posedge clock) reset |=> (rd_n && wr_n && !data_dir))
        else begin sva_errors++; $error("Strobes not released after reset"); end

    rsp_within_credit: assert property (@(posedge clock) disable iff (reset)
        rsp_valid |-> credits_left > 0)
        else begin sva_errors++; $error("Response sent without a credit"); end

endmodule

bind phase_bus_top phase_bus_sva sva_inst (.*);

`default_nettype wire

// File: tests/phase_bus_tb.sv
`default_nettype none
`timescale 1ns/10ps

module phase_bus_tb;

    localparam int  NUM_CMDS       = 60;
    localparam int  CYCLES_PER_CMD = 150; // Worst command plus back-pressure margin
    localparam time CLOCK_PERIOD   = 100ns;

    logic                clock;
    logic                reset;
    logic                cmd_valid;
    phase_bus_pkg::cmd_t cmd;
    logic                cmd_credit;
    logic                rsp_valid;
    phase_bus_pkg::rsp_t rsp;
    logic                rsp_credit;
    logic [3:0]          board_sel;
    logic [2:0]          addr_port;
    logic                rd_n;
    logic                wr_n;
    logic [7:0]          data_out;
    logic                data_dir;
    logic [7:0]          data_in;

    phase_bus_pkg::rsp_t expected_q [$];                       // In command order
    phase_bus_pkg::cmd_t cmd_list [NUM_CMDS];                  // Drawn right after seeding
    logic [7:0] shadow [phase_bus_pkg::NUM_BOARDS][3];          // Ports 0 to 2 per board
    // Opening write and read back, then ADC1 between full reads
    phase_bus_pkg::opcode_t lead_ops [6] = '{phase_bus_pkg::WRITE4, phase_bus_pkg::READ4,
        phase_bus_pkg::ADC4, phase_bus_pkg::ADC1, phase_bus_pkg::READ4, phase_bus_pkg::ADC4};

    int errors;
    int sent;
    int received;
    int send_credits;      // Sender side credit count
    int cmd_credit_pulses;
    int held_credits;      // Responses taken whose credit is not yet returned
    int hold_cycles;       // Back-pressure stretch left
    int hold_length;       // Long enough to fill both FIFOs
    bit hold_done;

    phase_bus_top uut (.*);
    board_model boards (.*);

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Result rule of the boards
    function automatic logic [7:0] adc_high(input int b, input logic [7:0] ch);
        return {4'(b), ch[3:0]};
    endfunction

    function automatic logic [7:0] adc_low(input int b, input logic [7:0] ch);
        return ch ^ 8'hA5 ^ 8'(b);
    endfunction

    function automatic phase_bus_pkg::cmd_t random_cmd(input int idx);
        phase_bus_pkg::cmd_t c;
        c.opcode  = (idx < 6) ? lead_ops[idx] : phase_bus_pkg::opcode_t'($urandom_range(3, 0));
        c.port    = (idx < 6) ? 3'd1 : 3'($urandom_range(2, 0));
        c.board   = 2'($urandom);
        c.channel = 8'($urandom);
        c.data    = 32'($urandom);
        return c;
    endfunction

    // Builds the expected response and tracks board ports in the shadow
    task automatic predict(input phase_bus_pkg::cmd_t c);
        phase_bus_pkg::rsp_t exp;
        exp        = '0;
        exp.opcode = c.opcode;
        case (c.opcode)
            phase_bus_pkg::WRITE4: begin
                for (int b = 0; b < phase_bus_pkg::NUM_BOARDS; b++) begin
                    shadow[b][c.port] = c.data[b];
                end
            end
            phase_bus_pkg::READ4: begin
                exp.count = 4'd4;
                for (int b = 0; b < phase_bus_pkg::NUM_BOARDS; b++) begin
                    exp.bytes[b] = shadow[b][c.port];
                end
            end
            phase_bus_pkg::ADC4: begin
                exp.count = 4'd8;
                for (int b = 0; b < phase_bus_pkg::NUM_BOARDS; b++) begin
                    exp.bytes[2 * b]     = adc_high(b, c.channel); // High then low
                    exp.bytes[2 * b + 1] = adc_low(b, c.channel);
                end
            end
            default: begin
                exp.count    = 4'd2; // ADC1 reads the named board only
                exp.bytes[0] = adc_high(int'(c.board), c.channel);
                exp.bytes[1] = adc_low(int'(c.board), c.channel);
            end
        endcase
        expected_q.push_back(exp);
    endtask

    task automatic check_rsp();
        phase_bus_pkg::rsp_t exp;
        string name;
        assert (expected_q.size() > 0) else begin
            errors++;
            $display("Response arrived with no command outstanding");
        end
        if (expected_q.size() > 0) begin
            exp  = expected_q.pop_front();
            name = $sformatf("rsp %0d %s", received, exp.opcode.name());
            assert (rsp == exp) else begin
                errors++;
                $display("[FAIL] %s expected %h actual %h", name, exp, rsp);
            end
        end
        received++;
    endtask

    // Sender spends one credit per command
    always @(negedge clock) begin
        cmd_valid = 1'b0;
        if (!reset) begin
            if (cmd_credit) begin
                cmd_credit_pulses++;
                send_credits++;
            end
            // A credit beyond the FIFO depth would let the sender overrun it
            assert (send_credits <= phase_bus_pkg::CMD_DEPTH) else begin
                errors++;
                $display("Command credit returned with no command outstanding");
            end
            if (send_credits > 0 && sent < NUM_CMDS) begin
                cmd       = cmd_list[sent];
                cmd_valid = 1'b1;
                predict(cmd);
                sent++;
                send_credits--;
            end
        end
    end

    // Consumer returns one credit per response unless held
    always @(negedge clock) begin
        rsp_credit = 1'b0;
        if (!reset) begin
            if (rsp_valid) begin
                check_rsp();
                held_credits++;
            end
            if (!hold_done && received == 8) begin
                hold_cycles = hold_length;
                hold_done   = 1'b1;
            end
            if (hold_cycles > 0) begin
                hold_cycles--;
            end else if (held_credits > 0) begin
                rsp_credit = 1'b1;
                held_credits--;
            end
        end
    end

    initial begin
        void'($urandom(32'ha4a9));
        for (int i = 0; i < NUM_CMDS; i++) begin
            cmd_list[i] = random_cmd(i);
        end
        hold_length = 1200 + $urandom_range(399, 0);
        errors = 0;
        sent = 0;
        received = 0;
        send_credits = phase_bus_pkg::CMD_DEPTH;
        cmd_credit_pulses = 0;
        held_credits = 0;
        hold_cycles = 0;
        hold_done = 1'b0;
        for (int b = 0; b < phase_bus_pkg::NUM_BOARDS; b++) begin
            for (int p = 0; p < 3; p++) begin
                shadow[b][p] = 8'h00;
            end
        end
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rsp_credit = 1'b0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        wait (received == NUM_CMDS);
        repeat (4) @(negedge clock);
        assert (cmd_credit_pulses == received) else begin
            errors++;
            $display("[FAIL] cmd_credit count expected %0d actual %0d",
                     received, cmd_credit_pulses);
        end
        assert (expected_q.size() == 0) else begin
            errors++;
            $display("Responses still expected at the end of the run");
        end
        $display("Errors: %0d check, %0d assertion", errors, uut.sva_inst.sva_errors);
        if (errors == 0 && uut.sva_inst.sva_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_CMDS * CYCLES_PER_CMD * CLOCK_PERIOD);
        $display("Timeout with %0d of %0d responses received", received, NUM_CMDS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
